// ==== Makefile ====
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := grn_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+hw
hw/host_if_pkg.sv
hw/grn_pkg.sv
hw/grn_generator.sv
hw/grn_line_fifo.sv
hw/grn_requestor.sv
hw/grn_top.sv
dv/grn_checker.sv
dv/grn_tb.sv

// ==== dv/grn_checker.sv ====
// protocol assertions on the write requestor, attached to every requestor instance by bind
`timescale 1ns/1ps

module grn_checker (
  input logic               clk,
  input logic               reset,
  input grn_pkg::wr_state_t state,
  input logic               take,
  input logic               avail,
  input logic               wr_almost_full,
  input logic               wr_valid
);

  int unsigned err_cnt = 0;

  // ********************
  // write channel
  // ********************

  // almost-full blocks the very next write
  bp_blocks_write: assert property (@(posedge clk) disable iff (reset)
    wr_almost_full |=> !wr_valid)
    else begin
      err_cnt++;
      $error("write issued after almost-full was sampled high");
    end

  take_needs_avail: assert property (@(posedge clk) disable iff (reset)
    take |-> avail)
    else begin
      err_cnt++;
      $error("line taken from an empty buffer");
    end

  take_makes_write: assert property (@(posedge clk) disable iff (reset)
    take |=> wr_valid)
    else begin
      err_cnt++;
      $error("taken line did not leave as a write");
    end

  // only the first cycle of the finished state carries the flag
  flag_once: assert property (@(posedge clk) disable iff (reset)
    (state == grn_pkg::wr_finish_2) && ($past(state) == grn_pkg::wr_finish_2) |-> !wr_valid)
    else begin
      err_cnt++;
      $error("write issued after the completion flag");
    end

endmodule : grn_checker

bind grn_requestor grn_checker u_checker (
  .clk            (clk),
  .reset          (reset),
  .state          (state),
  .take           (take),
  .avail          (avail),
  .wr_almost_full (wr_almost_full),
  .wr_valid       (wr_valid)
);

// ==== dv/grn_tb.sv ====
// testbench for the random line streamer, two streams against a response model and a reference
`timescale 1ns/1ps
`include "grn_defines.svh"

module grn_tb;

  localparam int LANE_W         = `GRN_CL_DATA_BITS / `GRN_LANES;
  localparam int RUN_A_LINES    = 12;
  localparam int RUN_B_LINES    = 40;
  localparam int TIMEOUT_CYCLES = 200 * (RUN_A_LINES + RUN_B_LINES) + 1000;

  logic                  clk;
  logic                  reset;
  grn_pkg::ctl_word_t    control;
  host_if_pkg::cl_addr_t dsm_base;
  host_if_pkg::cl_addr_t buf_base;
  grn_pkg::line_cnt_t    buf_size;
  logic                  wr_almost_full = 1'b0;
  logic                  wr_rsp_valid = 1'b0;
  logic                  wr_valid;
  host_if_pkg::cl_addr_t wr_addr;
  host_if_pkg::cl_data_t wr_data;

  // scoreboard
  bit                    started;
  bit                    heavy_bp;
  bit                    flag_seen;
  int                    cur_lines;
  int                    data_cnt;
  int                    rsp_seen;
  host_if_pkg::cl_addr_t exp_addr;
  host_if_pkg::cl_data_t exp_data;

  // memory model
  logic [31:0]           rng = 32'd80;
  int                    cycle;
  int                    delay;
  int                    due;
  int                    rsp_due[$];

  grn_top dut (
    .clk            (clk),
    .reset          (reset),
    .control        (control),
    .dsm_base       (dsm_base),
    .buf_base       (buf_base),
    .buf_size       (buf_size),
    .wr_almost_full (wr_almost_full),
    .wr_rsp_valid   (wr_rsp_valid),
    .wr_valid       (wr_valid),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ********************
  // helpers
  // ********************

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // one 13/7/17 step of a generator lane
  function automatic logic [LANE_W-1:0] lane_step(input logic [LANE_W-1:0] x);
    logic [LANE_W-1:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  // line n of the stream with every lane stepped n times from its seed
  function automatic host_if_pkg::cl_data_t ref_line(input int n);
    logic [LANE_W-1:0]     s;
    host_if_pkg::cl_data_t l;
    for (int i = 0; i < `GRN_LANES; i++) begin
      s = `GRN_SEED_BASE + 64'(i) * `GRN_SEED_STEP;
      for (int k = 0; k < n; k++) begin
        s = lane_step(s);
      end
      l[i*LANE_W +: LANE_W] = s;
    end
    return l;
  endfunction

  task automatic stop_run_failed();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input host_if_pkg::cl_data_t got,
                              input host_if_pkg::cl_data_t expected);
    $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, expected);
    stop_run_failed();
  endtask

  task automatic report_problem(input string what);
    $display("ERROR: %s", what);
    stop_run_failed();
  endtask

  // ********************
  // responses and back-pressure
  // ********************

  always @(posedge clk) begin
    if (reset) begin
      rsp_due.delete();
      wr_rsp_valid   <= 1'b0;
      wr_almost_full <= 1'b0;
    end else begin
      rng = xorshift32(rng);
      if (heavy_bp) begin
        wr_almost_full <= (rng[2:0] < 3'd5);
      end else begin
        wr_almost_full <= (rng[2:0] == 3'd0);
      end
      // one response per write 1 to 8 cycles later and at most one pulse a cycle
      if (wr_valid) begin
        delay = 1 + int'(rng[10:8]);
        due = cycle + delay;
        if ((rsp_due.size() > 0) && (due <= rsp_due[$])) begin
          due = rsp_due[$] + 1;
        end
        rsp_due.push_back(due);
      end
      if ((rsp_due.size() > 0) && (rsp_due[0] <= cycle)) begin
        wr_rsp_valid <= 1'b1;
        void'(rsp_due.pop_front());
      end else begin
        wr_rsp_valid <= 1'b0;
      end
    end
    cycle = cycle + 1;
  end

  // ********************
  // comparing process
  // ********************

  always @(negedge clk) begin
    if (reset) begin
      data_cnt  = 0;
      rsp_seen  = 0;
      flag_seen = 1'b0;
    end else begin
      if (dut.u_requestor.u_checker.err_cnt != 0) begin
        report_problem("a protocol assertion on the requestor failed");
      end
      if (wr_valid) begin
        if (!started) begin
          report_problem("write strobe seen before the start code");
        end else if (flag_seen) begin
          report_problem("write strobe seen after the completion flag");
        end else if (data_cnt < cur_lines) begin
          exp_addr = buf_base + host_if_pkg::cl_addr_t'(data_cnt);
          exp_data = ref_line(data_cnt);
          assert (wr_addr == exp_addr)
            else report_value("wr_addr", host_if_pkg::cl_data_t'(wr_addr),
                              host_if_pkg::cl_data_t'(exp_addr));
          assert (wr_data == exp_data)
            else report_value("wr_data", wr_data, exp_data);
          data_cnt++;
        end else begin
          // completion flag at the status line
          exp_addr = dsm_base + host_if_pkg::cl_addr_t'(1);
          exp_data = host_if_pkg::cl_data_t'(1);
          assert (wr_addr == exp_addr)
            else report_value("wr_addr", host_if_pkg::cl_data_t'(wr_addr),
                              host_if_pkg::cl_data_t'(exp_addr));
          assert (wr_data == exp_data)
            else report_value("wr_data", wr_data, exp_data);
          assert (rsp_seen == cur_lines)
            else report_value("wr_rsp_valid count", host_if_pkg::cl_data_t'(rsp_seen),
                              host_if_pkg::cl_data_t'(cur_lines));
          flag_seen = 1'b1;
        end
      end
      if (wr_rsp_valid) begin
        rsp_seen++;
      end
    end
  end

  // ********************
  // runs
  // ********************

  task automatic run_stream(input int lines, input bit heavy,
                            input host_if_pkg::cl_addr_t buf_addr,
                            input host_if_pkg::cl_addr_t dsm_addr);
    @(posedge clk);
    reset     <= 1'b1;
    control   <= '0;
    buf_base  <= buf_addr;
    dsm_base  <= dsm_addr;
    buf_size  <= grn_pkg::line_cnt_t'(lines);
    started   <= 1'b0;
    heavy_bp  <= heavy;
    cur_lines <= lines;
    repeat (10) @(posedge clk);
    reset   <= 1'b0;
    // requestor has to stay quiet on any word other than the start code
    control <= 32'h0000_00a5;
    repeat (8) @(posedge clk);
    control <= `GRN_CTL_START;
    started <= 1'b1;
    while (!flag_seen) begin
      @(posedge clk);
    end
    // late writes would show up here
    repeat (30) @(posedge clk);
  endtask

  initial begin
    reset    = 1'b1;
    control  = '0;
    dsm_base = '0;
    buf_base = '0;
    buf_size = '0;
    run_stream(RUN_A_LINES, 1'b0, 42'h000_0000_0100, 42'h000_0000_0080);
    run_stream(RUN_B_LINES, 1'b1, 42'h003_0000_0040, 42'h002_0000_0000);
    if (dut.u_requestor.u_checker.err_cnt == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      report_problem("a protocol assertion on the requestor failed");
    end
  end

  // watchdog over both runs
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    report_problem("timeout, the completion flag never arrived");
  end

endmodule : grn_tb

// ==== hw/grn_defines.svh ====
// common widths, start code, buffer depth and generator seeds, included by RTL and testbench
`ifndef GRN_DEFINES_SVH
`define GRN_DEFINES_SVH

// ********************
// host channel widths
// ********************

`define GRN_CL_ADDR_BITS 42
`define GRN_CL_DATA_BITS 512

// ********************
// control and counts
// ********************

`define GRN_CTL_BITS  32
`define GRN_CTL_START 32'h0000_0001
`define GRN_CNT_BITS  16

// four lines between generator and requestor
`define GRN_FIFO_DEPTH_LOG2 2

// ********************
// generator
// ********************

`define GRN_LANES 8

// lane i starts at base + i * step, step is odd so no two lanes share a seed
`define GRN_SEED_BASE 64'h2545_F491_4F6C_DD1D
`define GRN_SEED_STEP 64'h9E37_79B9_7F4A_7C15

`endif

// ==== hw/grn_generator.sv ====
// line producer, eight xorshift64 lanes stepped once for every line pushed into the buffer
`timescale 1ns/1ps
`include "grn_defines.svh"

module grn_generator (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  run,
  input  logic                  full,
  output logic                  push,
  output host_if_pkg::cl_data_t line
);

  localparam int LANE_BITS = `GRN_CL_DATA_BITS / `GRN_LANES;

  logic [LANE_BITS-1:0] lane [`GRN_LANES];
  logic                 step;

  // standard 13/7/17 xorshift on 64 bits
  function automatic logic [LANE_BITS-1:0] xorshift64(input logic [LANE_BITS-1:0] x);
    logic [LANE_BITS-1:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 7);
    y = y ^ (y << 17);
    return y;
  endfunction

  // a line leaves whenever the buffer has room
  assign step = run && !full;
  assign push = step;

  // lane 0 in the low bits
  always_comb begin
    for (int i = 0; i < `GRN_LANES; i++) begin
      line[i*LANE_BITS +: LANE_BITS] = lane[i];
    end
  end

  // ********************
  // lane state
  // ********************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      // restart from the seeds so each run repeats the same stream
      for (int i = 0; i < `GRN_LANES; i++) begin
        lane[i] <= `GRN_SEED_BASE + LANE_BITS'(i) * `GRN_SEED_STEP;
      end
    end else if (step) begin
      for (int i = 0; i < `GRN_LANES; i++) begin
        lane[i] <= xorshift64(lane[i]);
      end
    end
  end

endmodule : grn_generator

// ==== hw/grn_line_fifo.sv ====
// show-ahead line FIFO that absorbs rate differences between generator and requestor
`timescale 1ns/1ps
`include "grn_defines.svh"

module grn_line_fifo (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  host_if_pkg::cl_data_t line_in,
  output logic                  full,
  output logic                  avail,
  output host_if_pkg::cl_data_t head,
  input  logic                  take
);

  localparam int AW    = `GRN_FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << AW;

  host_if_pkg::cl_data_t mem [DEPTH];

  // extra msb tells a full ring from an empty one
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        wr_en;
  logic        rd_en;

  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign avail = (wr_ptr != rd_ptr);

  assign wr_en = push && !full;
  assign rd_en = take && avail;

  // oldest line is always on the output
  assign head = mem[rd_ptr[AW-1:0]];

  // ********************
  // storage
  // ********************

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= line_in;
    end
  end

  // ********************
  // pointers
  // ********************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule : grn_line_fifo

// ==== hw/grn_pkg.sv ====
// generator subsystem types: host control word, line counts and requestor states
`include "grn_defines.svh"

package grn_pkg;

  // ********************
  // host side settings
  // ********************

  typedef logic [`GRN_CTL_BITS-1:0] ctl_word_t;

  // buffer size, write offset and response count
  typedef logic [`GRN_CNT_BITS-1:0] line_cnt_t;

  // ********************
  // requestor FSM
  // ********************

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_finish_1,
    wr_finish_2
  } wr_state_t;

endpackage : grn_pkg

// ==== hw/grn_requestor.sv ====
// write requestor FSM, streams buffered lines to the host buffer and posts the completion flag
`timescale 1ns/1ps
`include "grn_defines.svh"

module grn_requestor (
  input  logic                  clk,
  input  logic                  reset,
  input  grn_pkg::ctl_word_t    control,
  input  host_if_pkg::cl_addr_t dsm_base,
  input  host_if_pkg::cl_addr_t buf_base,
  input  grn_pkg::line_cnt_t    buf_size,
  input  logic                  avail,
  input  host_if_pkg::cl_data_t head,
  output logic                  take,
  output logic                  gen_run,
  input  logic                  wr_almost_full,
  input  logic                  wr_rsp_valid,
  output logic                  wr_valid,
  output host_if_pkg::cl_addr_t wr_addr,
  output host_if_pkg::cl_data_t wr_data
);

  grn_pkg::wr_state_t state;
  grn_pkg::wr_state_t next_state;

  grn_pkg::line_cnt_t wr_offset;
  grn_pkg::line_cnt_t rsp_cnt;

  logic start;
  logic last_line;
  logic flag_go;

  assign start = (control == `GRN_CTL_START);

  // pop the head in the cycle it is captured into the write register
  assign take = (state == grn_pkg::wr_data) && avail && !wr_almost_full;

  assign last_line = (grn_pkg::line_cnt_t'(wr_offset + 1'b1) == buf_size);

  // every data line acknowledged and the channel has room
  assign flag_go = (state == grn_pkg::wr_finish_1) && (rsp_cnt == buf_size) &&
                   !wr_almost_full;

  // ********************
  // state machine
  // ********************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= grn_pkg::wr_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      grn_pkg::wr_idle: begin
        if (start) begin
          next_state = grn_pkg::wr_data;
        end
      end
      grn_pkg::wr_data: begin
        if (take && last_line) begin
          next_state = grn_pkg::wr_finish_1;
        end
      end
      grn_pkg::wr_finish_1: begin
        if (flag_go) begin
          next_state = grn_pkg::wr_finish_2;
        end
      end
      // finished, only reset leaves
      default: begin
        next_state = state;
      end
    endcase
  end

  // ********************
  // counters and strobes
  // ********************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_offset <= '0;
      rsp_cnt   <= '0;
      gen_run   <= 1'b0;
      wr_valid  <= 1'b0;
    end else begin
      if ((state == grn_pkg::wr_idle) && start) begin
        gen_run <= 1'b1;
      end
      if (take) begin
        wr_offset <= wr_offset + 1'b1;
      end
      if (wr_rsp_valid) begin
        rsp_cnt <= rsp_cnt + 1'b1;
      end
      wr_valid <= take || flag_go;
    end
  end

  // write payload, only meaningful while wr_valid is high
  always_ff @(posedge clk) begin
    if (take) begin
      wr_addr <= buf_base + host_if_pkg::cl_addr_t'(wr_offset);
      wr_data <= head;
    end else if (flag_go) begin
      wr_addr <= dsm_base + 1'b1;
      wr_data <= host_if_pkg::cl_data_t'(1);
    end
  end

endmodule : grn_requestor

// ==== hw/grn_top.sv ====
// random line streamer top level, generator feeds the line FIFO which feeds the write requestor
`timescale 1ns/1ps

module grn_top (
  input  logic                  clk,
  input  logic                  reset,
  input  grn_pkg::ctl_word_t    control,
  input  host_if_pkg::cl_addr_t dsm_base,
  input  host_if_pkg::cl_addr_t buf_base,
  input  grn_pkg::line_cnt_t    buf_size,
  input  logic                  wr_almost_full,
  input  logic                  wr_rsp_valid,
  output logic                  wr_valid,
  output host_if_pkg::cl_addr_t wr_addr,
  output host_if_pkg::cl_data_t wr_data
);

  logic                  gen_run;
  logic                  push;
  logic                  full;
  logic                  avail;
  logic                  take;
  host_if_pkg::cl_data_t gen_line;
  host_if_pkg::cl_data_t head;

  // ********************
  // producer
  // ********************

  grn_generator u_generator (
    .clk   (clk),
    .reset (reset),
    .run   (gen_run),
    .full  (full),
    .push  (push),
    .line  (gen_line)
  );

  // ********************
  // line buffer
  // ********************

  grn_line_fifo u_fifo (
    .clk     (clk),
    .reset   (reset),
    .push    (push),
    .line_in (gen_line),
    .full    (full),
    .avail   (avail),
    .head    (head),
    .take    (take)
  );

  // ********************
  // host writes
  // ********************

  grn_requestor u_requestor (
    .clk            (clk),
    .reset          (reset),
    .control        (control),
    .dsm_base       (dsm_base),
    .buf_base       (buf_base),
    .buf_size       (buf_size),
    .avail          (avail),
    .head           (head),
    .take           (take),
    .gen_run        (gen_run),
    .wr_almost_full (wr_almost_full),
    .wr_rsp_valid   (wr_rsp_valid),
    .wr_valid       (wr_valid),
    .wr_addr        (wr_addr),
    .wr_data        (wr_data)
  );

endmodule : grn_top

// ==== hw/host_if_pkg.sv ====
// host memory channel types, used by every block that carries addresses or line data
`include "grn_defines.svh"

package host_if_pkg;

  // ********************
  // write channel payload
  // ********************

  // cache-line address, one step is one 64-byte line
  typedef logic [`GRN_CL_ADDR_BITS-1:0] cl_addr_t;

  // one full cache line of payload
  typedef logic [`GRN_CL_DATA_BITS-1:0] cl_data_t;

endpackage : host_if_pkg
